// ==== flist.f ====
+incdir+logic
logic/cache_geom_pkg.sv
logic/cache_msg_pkg.sv
logic/req_decode.sv
logic/cache_ctrl.sv
logic/tag_state_array.sv
logic/data_array.sv
logic/mem_port.sv
logic/resp_unit.sv
logic/cache_top.sv
testbench/cache_properties.sv
testbench/cache_tb.sv

// ==== testbench/cache_tb.sv ====
//--------------------------------------------------------------------------
// Cache testbench: clock, reset, LCG stimulus, memory responder,
// reference cache model, compare tasks and timeout
//--------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cache_config.svh"

module cache_tb;

  localparam int NUM_INITS      = 2 * `CACHE_NUM_SETS;  // Both ways of every set
  localparam int NUM_OPS        = 400;                  // Random reads and writes
  localparam int NUM_SLOTS      = 24;                   // 3 tags per set
  localparam int RESET_CYCLES   = 3;
  localparam int IDLE_CYCLES    = 4;
  localparam int TIMEOUT_CYCLES = 40 * (NUM_INITS + NUM_OPS) + RESET_CYCLES + IDLE_CYCLES;
  localparam int TAG_BASE       = 32'h0012_d4e0;
  localparam int TAG_STEP       = 32'h0003_9a17;         // Spreads the 3 tags apart

  logic                     clk;
  logic                     reset;
  logic                     cache_req_valid;
  cache_msg_pkg::req_type_t cache_req_type;
  cache_geom_pkg::addr_t    cache_req_addr;
  cache_geom_pkg::data_t    cache_req_data;
  logic                     cache_resp_valid;
  cache_msg_pkg::req_type_t cache_resp_type;
  cache_geom_pkg::data_t    cache_resp_data;
  logic                     cache_resp_hit;
  logic                     mem_req_valid;
  cache_msg_pkg::mem_op_t   mem_req_op;
  cache_geom_pkg::addr_t    mem_req_addr;
  cache_geom_pkg::data_t    mem_req_data;
  logic                     mem_resp_valid;
  cache_geom_pkg::data_t    mem_resp_data;

  // Reference model, one entry per way and set
  cache_geom_pkg::tag_t  m_tag   [0:1][0:`CACHE_NUM_SETS-1];
  logic                  m_valid [0:1][0:`CACHE_NUM_SETS-1];
  logic                  m_dirty [0:1][0:`CACHE_NUM_SETS-1];
  cache_geom_pkg::data_t m_data  [0:1][0:`CACHE_NUM_SETS-1];
  logic                  m_lru   [0:`CACHE_NUM_SETS-1];  // Way to replace next
  cache_geom_pkg::data_t ref_mem   [0:NUM_SLOTS-1];      // Model view of memory
  cache_geom_pkg::data_t mem_words [0:NUM_SLOTS-1];      // Responder memory

  // Memory requests the model expects, oldest first
  cache_msg_pkg::mem_op_t exp_op_q   [$];
  cache_geom_pkg::addr_t  exp_addr_q [$];
  cache_geom_pkg::data_t  exp_data_q [$];

  logic [31:0] stim_state;
  logic [31:0] delay_state;
  int          mem_req_count = 0;
  int          cycle_count   = 0;
  int          hit_count     = 0;
  int          evict_count   = 0;

  cache_top u_cache_top (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  //------------------------------------------------------------------------
  // Helpers and compare tasks
  //------------------------------------------------------------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // Slot s maps to set s % 8 and tag number s / 8
  function automatic cache_geom_pkg::addr_t slot_addr(input int slot);
    cache_geom_pkg::tag_t tag;
    tag = cache_geom_pkg::tag_t'(TAG_BASE + (slot / 8) * TAG_STEP);
    return {tag, cache_geom_pkg::index_t'(slot % 8), 2'b00};
  endfunction

  function automatic int slot_of(input cache_geom_pkg::addr_t addr);
    for (int s = 0; s < NUM_SLOTS; s++)
      if (slot_addr(s) == addr)
        return s;
    return -1;                              // Not one of the test addresses
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input string name, input cache_geom_pkg::data_t got,
                            input cache_geom_pkg::data_t exp);
    if (got !== exp)
      fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_addr(input string name, input cache_geom_pkg::addr_t got,
                            input cache_geom_pkg::addr_t exp);
    if (got !== exp)
      fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_type(input string name, input cache_msg_pkg::req_type_t got,
                            input cache_msg_pkg::req_type_t exp);
    if (got !== exp)
      fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_op(input string name, input cache_msg_pkg::mem_op_t got,
                          input cache_msg_pkg::mem_op_t exp);
    if (got !== exp)
      fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
      fail_now($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  //------------------------------------------------------------------------
  // Memory responder, one request at a time, 1 to 8 cycles of delay
  //------------------------------------------------------------------------

  initial begin : memory_responder
    int                    delay;
    int                    slot;
    logic                  is_write;
    cache_geom_pkg::data_t exp_word;
    forever begin
      @(negedge clk);
      if (mem_req_valid) begin
        mem_req_count++;
        if (exp_op_q.size() == 0)
          fail_now("memory request issued while the model expects none");
        is_write = (mem_req_op == cache_msg_pkg::MEM_WRITE);
        check_op("mem_req_op", mem_req_op, exp_op_q.pop_front());
        check_addr("mem_req_addr", mem_req_addr, exp_addr_q.pop_front());
        exp_word = exp_data_q.pop_front();
        if (is_write)
          check_data("mem_req_data", mem_req_data, exp_word);  // Dirty victim word
        slot = slot_of(mem_req_addr);
        if (slot < 0)
          fail_now("memory request to an address outside the test set");
        if (is_write)
          mem_words[slot] = mem_req_data;
        delay_state = lcg_next(delay_state);
        delay = 1 + delay_state[31:16] % 8;
        repeat (delay) @(negedge clk);
        mem_resp_valid = 1'b1;             // Also acknowledges a writeback
        mem_resp_data  = is_write ? '0 : mem_words[slot];
        @(negedge clk);
        mem_resp_valid = 1'b0;
        mem_resp_data  = '0;
      end
    end
  end

  // Run limit from the number of operations
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES)
      fail_now($sformatf("timeout after %0d cycles, the cache stopped answering",
                         cycle_count));
  end

  //------------------------------------------------------------------------
  // One request: model prediction, drive, wait for response, compare
  //------------------------------------------------------------------------

  task automatic run_op(input cache_msg_pkg::req_type_t kind, input int slot,
                        input cache_geom_pkg::data_t wdata);
    cache_geom_pkg::addr_t  addr;
    cache_geom_pkg::addr_t  vaddr;
    cache_geom_pkg::index_t idx;
    cache_geom_pkg::tag_t   tag;
    cache_geom_pkg::data_t  exp_data;
    logic                   exp_hit;
    int                     way;
    int                     vslot;
    int                     exp_mem;
    int                     count_before;
    int                     cycles;
    addr     = slot_addr(slot);
    idx      = addr[4:2];
    tag      = addr[31:5];
    exp_hit  = 1'b0;
    exp_mem  = 0;
    exp_data = '0;
    way      = m_lru[idx];                 // Victim unless a way matches
    for (int w = 0; w < 2; w++) begin
      if (m_valid[w][idx] && m_tag[w][idx] == tag) begin
        exp_hit = 1'b1;
        way     = w;
      end
    end
    if (kind == cache_msg_pkg::REQ_INIT) begin
      m_tag[way][idx]   = tag;
      m_valid[way][idx] = 1'b1;
      m_dirty[way][idx] = 1'b0;            // Installed clean, memory gets the word too
      m_data[way][idx]  = wdata;
      ref_mem[slot]     = wdata;
      mem_words[slot]   = wdata;
    end else begin
      if (exp_hit)
        hit_count++;
      else begin
        if (m_dirty[way][idx]) begin
          vaddr = {m_tag[way][idx], idx, 2'b00};
          vslot = slot_of(vaddr);
          if (vslot < 0)
            fail_now("model victim address outside the test set");
          exp_op_q.push_back(cache_msg_pkg::MEM_WRITE);
          exp_addr_q.push_back(vaddr);
          exp_data_q.push_back(m_data[way][idx]);
          ref_mem[vslot] = m_data[way][idx];
          exp_mem++;
          evict_count++;
        end
        exp_op_q.push_back(cache_msg_pkg::MEM_READ);  // Refill of the missing line
        exp_addr_q.push_back(addr);
        exp_data_q.push_back('0);
        exp_mem++;
        m_tag[way][idx]   = tag;
        m_valid[way][idx] = 1'b1;
        m_dirty[way][idx] = 1'b0;
        m_data[way][idx]  = ref_mem[slot];
      end
      if (kind == cache_msg_pkg::REQ_READ)
        exp_data = m_data[way][idx];
      else begin
        m_data[way][idx]  = wdata;
        m_dirty[way][idx] = 1'b1;
      end
    end
    m_lru[idx] = (way == 0);               // Other way goes next
    count_before = mem_req_count;

    // Called on a falling edge
    cache_req_valid = 1'b1;
    cache_req_type  = kind;
    cache_req_addr  = addr;
    cache_req_data  = wdata;
    cycles = 0;
    do begin
      @(negedge clk);
      cache_req_valid = 1'b0;              // Single-cycle strobe
      cycles++;
    end while (!cache_resp_valid);

    check_type("cache_resp_type", cache_resp_type, kind);
    check_data("cache_resp_data", cache_resp_data, exp_data);
    check_bit("cache_resp_hit", cache_resp_hit, exp_hit);
    if ((exp_hit || kind == cache_msg_pkg::REQ_INIT) && cycles != 3)
      fail_now($sformatf("hit or init answered after %0d cycles instead of 3", cycles));
    if (mem_req_count - count_before != exp_mem)
      fail_now($sformatf("request caused %0d memory requests, the model expects %0d",
                         mem_req_count - count_before, exp_mem));
  endtask

  //------------------------------------------------------------------------
  // Main sequence
  //------------------------------------------------------------------------

  initial begin : main_sequence
    cache_msg_pkg::req_type_t kind;
    int                       slot;
    cache_geom_pkg::addr_t    fill_addr;
    reset           = 1'b1;
    cache_req_valid = 1'b0;
    cache_req_type  = cache_msg_pkg::REQ_READ;
    cache_req_addr  = '0;
    cache_req_data  = '0;
    mem_resp_valid  = 1'b0;
    mem_resp_data   = '0;
    stim_state      = 32'h290dbcd7;
    delay_state     = lcg_next(32'h290dbcd7);  // Separate stream for memory delays
    for (int s = 0; s < `CACHE_NUM_SETS; s++) begin
      m_lru[s] = 1'b0;
      for (int w = 0; w < 2; w++) begin
        m_valid[w][s] = 1'b0;
        m_dirty[w][s] = 1'b0;
      end
    end
    for (int s = 0; s < NUM_SLOTS; s++) begin
      fill_addr    = slot_addr(s);
      mem_words[s] = fill_addr ^ {fill_addr[15:0], fill_addr[31:16]} ^ 32'h5a3c_96e1;
      ref_mem[s]   = mem_words[s];
    end

    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;

    // Quiet ports before the first request
    repeat (IDLE_CYCLES) begin
      @(negedge clk);
      check_bit("cache_resp_valid", cache_resp_valid, 1'b0);
      check_bit("mem_req_valid", mem_req_valid, 1'b0);
    end

    // Preload, way 0 then way 1 of every set
    for (int s = 0; s < NUM_INITS; s++) begin
      stim_state = lcg_next(stim_state);
      run_op(cache_msg_pkg::REQ_INIT, s, stim_state);
    end

    for (int i = 0; i < NUM_OPS; i++) begin
      stim_state = lcg_next(stim_state);
      kind = stim_state[31] ? cache_msg_pkg::REQ_WRITE : cache_msg_pkg::REQ_READ;
      slot = stim_state[23:8] % NUM_SLOTS;
      stim_state = lcg_next(stim_state);
      run_op(kind, slot, stim_state);
    end

    if (evict_count == 0)
      fail_now("random phase produced no dirty writeback");
    if (u_cache_top.u_cache_properties.fail_count != 0)
      fail_now("a strobe protocol assertion on the cache ports failed");
    $display("%0d operations, %0d hits, %0d writebacks", NUM_OPS, hit_count, evict_count);
    if (exp_op_q.size() != 0)
      fail_now("memory requests expected by the model never arrived");
    else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// ==== testbench/cache_properties.sv ====
//--------------------------------------------------------------------------
// Strobe protocol assertions, bound into the cache top level
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module cache_properties (
  input logic clk,
  input logic reset,
  input logic cache_req_valid,
  input logic cache_resp_valid,
  input logic mem_req_valid,
  input logic mem_resp_valid
);

  logic req_pending;  // Processor request taken, no response yet
  logic mem_pending;  // Memory request out, no response yet
  int   fail_count = 0;  // Assertion failures so far

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_pending <= 1'b0;
      mem_pending <= 1'b0;
    end else begin
      if (cache_req_valid)
        req_pending <= 1'b1;  // New request may share the edge with the old response
      else if (cache_resp_valid)
        req_pending <= 1'b0;
      if (mem_req_valid)
        mem_pending <= 1'b1;
      else if (mem_resp_valid)
        mem_pending <= 1'b0;
    end
  end

  resp_single_cycle: assert property (@(posedge clk) disable iff (reset)
    cache_resp_valid |=> !cache_resp_valid)
    else begin
      $error("response strobe high on two consecutive cycles");
      fail_count++;
    end

  mem_one_outstanding: assert property (@(posedge clk) disable iff (reset)
    mem_req_valid |-> !mem_pending)
    else begin
      $error("memory request issued before the previous one was answered");
      fail_count++;
    end

  resp_after_req: assert property (@(posedge clk) disable iff (reset)
    cache_resp_valid |-> req_pending)
    else begin
      $error("response with no request outstanding");
      fail_count++;
    end

endmodule

bind cache_top cache_properties u_cache_properties (
  .clk              (clk),
  .reset            (reset),
  .cache_req_valid  (cache_req_valid),
  .cache_resp_valid (cache_resp_valid),
  .mem_req_valid    (mem_req_valid),
  .mem_resp_valid   (mem_resp_valid)
);

// ==== logic/cache_top.sv ====
//--------------------------------------------------------------------------
// Cache top: decode, controller, arrays, memory port, response unit
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module cache_top (
  input  logic                     clk,
  input  logic                     reset,
  // Processor port
  input  logic                     cache_req_valid,
  input  cache_msg_pkg::req_type_t cache_req_type,
  input  cache_geom_pkg::addr_t    cache_req_addr,
  input  cache_geom_pkg::data_t    cache_req_data,
  output logic                     cache_resp_valid,
  output cache_msg_pkg::req_type_t cache_resp_type,
  output cache_geom_pkg::data_t    cache_resp_data,
  output logic                     cache_resp_hit,
  // Memory port
  output logic                     mem_req_valid,
  output cache_msg_pkg::mem_op_t   mem_req_op,
  output cache_geom_pkg::addr_t    mem_req_addr,
  output cache_geom_pkg::data_t    mem_req_data,
  input  logic                     mem_resp_valid,
  input  cache_geom_pkg::data_t    mem_resp_data
);

  //------------------------------------------------------------------------
  // Internal wiring
  //------------------------------------------------------------------------

  logic                     req_start;
  cache_msg_pkg::req_type_t req_type;
  cache_geom_pkg::tag_t     req_tag;
  cache_geom_pkg::index_t   req_index;
  cache_geom_pkg::data_t    req_data;
  logic                     tag_check, fill_line, write_word, touch_lru;
  logic                     evict_issue, refill_issue, read_capture, resp_fire;
  logic                     req_is_init;  // Level, high in the init access
  logic                     hit, victim_dirty;
  cache_geom_pkg::way_t     sel_way;
  cache_geom_pkg::tag_t     victim_tag;
  cache_geom_pkg::data_t    rd_data;

  req_decode u_req_decode (.*);          // Decode stage

  cache_ctrl u_cache_ctrl (.*);          // Execute stage

  tag_state_array u_tag_state_array (.*);

  data_array u_data_array (.*);

  mem_port u_mem_port (.*);

  resp_unit u_resp_unit (.*);            // Result stage

endmodule

// ==== logic/resp_unit.sv ====
//--------------------------------------------------------------------------
// Processor response register: read word, request kind, hit flag
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module resp_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     tag_check,
  input  logic                     hit,
  input  logic                     read_capture,
  input  logic                     resp_fire,
  input  cache_msg_pkg::req_type_t req_type,
  input  cache_geom_pkg::data_t    rd_data,
  output logic                     cache_resp_valid,
  output cache_msg_pkg::req_type_t cache_resp_type,
  output cache_geom_pkg::data_t    cache_resp_data,
  output logic                     cache_resp_hit
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cache_resp_valid <= 1'b0;
    end else begin
      cache_resp_valid <= resp_fire;  // Single-cycle strobe
    end
  end

  always_ff @(posedge clk) begin
    if (tag_check) begin
      cache_resp_hit  <= hit;  // Result of the first tag compare
      cache_resp_data <= '0;   // Writes and inits answer with zero
    end else if (read_capture) begin
      cache_resp_data <= rd_data;
    end
    if (resp_fire)
      cache_resp_type <= req_type;
  end

endmodule

// ==== logic/mem_port.sv ====
//--------------------------------------------------------------------------
// Memory request register for writeback and refill
//--------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cache_config.svh"

module mem_port (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   evict_issue,
  input  logic                   refill_issue,
  input  cache_geom_pkg::tag_t   victim_tag,
  input  cache_geom_pkg::tag_t   req_tag,
  input  cache_geom_pkg::index_t req_index,
  input  cache_geom_pkg::data_t  rd_data,
  output logic                   mem_req_valid,
  output cache_msg_pkg::mem_op_t mem_req_op,
  output cache_geom_pkg::addr_t  mem_req_addr,
  output cache_geom_pkg::data_t  mem_req_data
);

  localparam int OFFSET_W = `CACHE_ADDR_W - `CACHE_TAG_W - `CACHE_INDEX_W;

  // Request strobe, one cycle behind the issue
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mem_req_valid <= 1'b0;
    end else begin
      mem_req_valid <= evict_issue | refill_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (evict_issue) begin
      mem_req_op   <= cache_msg_pkg::MEM_WRITE;
      mem_req_addr <= {victim_tag, req_index, {OFFSET_W{1'b0}}};  // Victim line
      mem_req_data <= rd_data;                                    // Dirty word
    end else if (refill_issue) begin
      mem_req_op   <= cache_msg_pkg::MEM_READ;
      mem_req_addr <= {req_tag, req_index, {OFFSET_W{1'b0}}};     // Missing line
      mem_req_data <= '0;
    end
  end

endmodule

// ==== logic/data_array.sv ====
//--------------------------------------------------------------------------
// Two-way word storage, write source mux and combinational read
//--------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cache_config.svh"

module data_array (
  input  logic                   clk,
  input  cache_geom_pkg::index_t req_index,
  input  cache_geom_pkg::way_t   sel_way,
  input  logic                   fill_line,
  input  logic                   write_word,
  input  cache_geom_pkg::data_t  req_data,
  input  cache_geom_pkg::data_t  mem_resp_data,
  output cache_geom_pkg::data_t  rd_data
);

  cache_geom_pkg::data_t words_q [0:1][0:`CACHE_NUM_SETS-1];

  // Processor word wins when both fire, as for an init
  always_ff @(posedge clk) begin
    if (write_word)
      words_q[sel_way][req_index] <= req_data;
    else if (fill_line)
      words_q[sel_way][req_index] <= mem_resp_data;  // Refill from memory
  end

  // Read port feeds the response and the writeback
  assign rd_data = words_q[sel_way][req_index];

endmodule

// ==== logic/tag_state_array.sv ====
//--------------------------------------------------------------------------
// Tag, valid and dirty arrays per way, LRU per set, hit and victim way
//--------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cache_config.svh"

module tag_state_array (
  input  logic                   clk,
  input  logic                   reset,
  input  cache_geom_pkg::tag_t   req_tag,
  input  cache_geom_pkg::index_t req_index,
  input  logic                   tag_check,
  input  logic                   fill_line,
  input  logic                   write_word,
  input  logic                   touch_lru,
  input  logic                   req_is_init,
  output logic                   hit,
  output logic                   victim_dirty,
  output cache_geom_pkg::way_t   sel_way,
  output cache_geom_pkg::tag_t   victim_tag
);

  cache_geom_pkg::tag_t              tags_q [0:1][0:`CACHE_NUM_SETS-1];
  logic [1:0][`CACHE_NUM_SETS-1:0]   valid_q;
  logic [1:0][`CACHE_NUM_SETS-1:0]   dirty_q;
  logic [`CACHE_NUM_SETS-1:0]        lru_q;    // Way to replace next
  logic [1:0]                        match;
  cache_geom_pkg::way_t              pick_way;

  // Tag compare, qualified by valid
  assign match[0] = valid_q[0][req_index] && (tags_q[0][req_index] == req_tag);
  assign match[1] = valid_q[1][req_index] && (tags_q[1][req_index] == req_tag);
  assign hit      = |match;

  // Hit way, else the LRU way of the set
  assign pick_way     = hit ? match[1] : lru_q[req_index];
  assign victim_dirty = dirty_q[pick_way][req_index];  // Needed in the check cycle
  assign victim_tag   = tags_q[sel_way][req_index];    // Writeback address

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      sel_way <= 1'b0;
      valid_q <= '0;
      dirty_q <= '0;
      lru_q   <= '0;
    end else begin
      if (tag_check)
        sel_way <= pick_way;                  // Held for the rest of the request
      if (fill_line) begin
        valid_q[sel_way][req_index] <= 1'b1;
        dirty_q[sel_way][req_index] <= 1'b0;  // Fresh line is clean
      end
      if (write_word && !req_is_init)
        dirty_q[sel_way][req_index] <= 1'b1;
      if (touch_lru)
        lru_q[req_index] <= ~sel_way;         // Point at the other way
    end
  end

  // Tag storage
  always_ff @(posedge clk) begin
    if (fill_line)
      tags_q[sel_way][req_index] <= req_tag;
  end

endmodule

// ==== logic/cache_ctrl.sv ====
//--------------------------------------------------------------------------
// Cache controller FSM: tag check, access, evict, refill and response
//--------------------------------------------------------------------------

`timescale 1ns/1ns

module cache_ctrl (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_start,
  input  cache_msg_pkg::req_type_t req_type,
  input  logic                     hit,
  input  logic                     victim_dirty,
  input  logic                     mem_resp_valid,
  output logic                     tag_check,
  output logic                     fill_line,
  output logic                     write_word,
  output logic                     touch_lru,
  output logic                     evict_issue,
  output logic                     refill_issue,
  output logic                     read_capture,
  output logic                     resp_fire,
  output logic                     req_is_init
);

  typedef enum logic [3:0] {
    IDLE, TAG_CHECK, INIT_ACCESS, READ_ACCESS, WRITE_ACCESS,
    EVICT_REQUEST, EVICT_WAIT, REFILL_REQUEST, REFILL_WAIT,
    REFILL_UPDATE, RESPOND
  } state_t;

  state_t     state_q;
  state_t     state_cur;
  state_t     state_nxt;
  logic [8:0] ctrl_word;  // One row of the control table

  // The start cycle is the tag check itself, so a hit answers in 3 cycles
  assign state_cur = (state_q == IDLE && req_start) ? TAG_CHECK : state_q;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_nxt;
    end
  end

  //------------------------------------------------------------------------
  // Next state
  //------------------------------------------------------------------------

  always_comb begin
    state_nxt = state_cur;
    case (state_cur)
      IDLE:           state_nxt = IDLE;  // Left only through the start fold
      TAG_CHECK: begin
        if (req_type == cache_msg_pkg::REQ_INIT)
          state_nxt = INIT_ACCESS;
        else if (hit && req_type == cache_msg_pkg::REQ_READ)
          state_nxt = READ_ACCESS;
        else if (hit)
          state_nxt = WRITE_ACCESS;
        else if (victim_dirty)
          state_nxt = EVICT_REQUEST;     // Dirty victim goes out first
        else
          state_nxt = REFILL_REQUEST;
      end
      INIT_ACCESS,
      READ_ACCESS,
      WRITE_ACCESS:   state_nxt = RESPOND;
      EVICT_REQUEST:  state_nxt = EVICT_WAIT;
      EVICT_WAIT:     state_nxt = mem_resp_valid ? REFILL_REQUEST : EVICT_WAIT;
      REFILL_REQUEST: state_nxt = REFILL_WAIT;
      REFILL_WAIT:    state_nxt = mem_resp_valid ? REFILL_UPDATE : REFILL_WAIT;
      REFILL_UPDATE:  state_nxt = (req_type == cache_msg_pkg::REQ_READ) ? READ_ACCESS
                                                                          : WRITE_ACCESS;
      RESPOND:        state_nxt = IDLE;  // Response strobe is on the port
      default:        state_nxt = IDLE;
    endcase
  end

  //------------------------------------------------------------------------
  // Control table
  //------------------------------------------------------------------------

  always_comb begin
    ctrl_word = '0;
    case (state_cur)
      //                          tag fil wr  lru evc rfl rdc rsp ini
      TAG_CHECK:      ctrl_word = 9'b1___0___0___0___0___0___0___0___0;
      INIT_ACCESS:    ctrl_word = 9'b0___1___1___1___0___0___0___1___1;
      READ_ACCESS:    ctrl_word = 9'b0___0___0___1___0___0___1___1___0;
      WRITE_ACCESS:   ctrl_word = 9'b0___0___1___1___0___0___0___1___0;
      EVICT_REQUEST:  ctrl_word = 9'b0___0___0___0___1___0___0___0___0;
      REFILL_REQUEST: ctrl_word = 9'b0___0___0___0___0___1___0___0___0;
      // Refill word is only present in the strobe cycle
      REFILL_WAIT:    ctrl_word = mem_resp_valid ? 9'b0___1___0___0___0___0___0___0___0
                                                 : 9'b0;
      default:        ctrl_word = '0;  // IDLE, waits, REFILL_UPDATE, RESPOND
    endcase
  end

  assign {tag_check, fill_line, write_word, touch_lru, evict_issue,
          refill_issue, read_capture, resp_fire, req_is_init} = ctrl_word;

endmodule

// ==== logic/req_decode.sv ====
//--------------------------------------------------------------------------
// Request register: address split into tag and index, start strobe
//--------------------------------------------------------------------------

`timescale 1ns/1ns

`include "cache_config.svh"

module req_decode (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     cache_req_valid,
  input  cache_msg_pkg::req_type_t cache_req_type,
  input  cache_geom_pkg::addr_t    cache_req_addr,
  input  cache_geom_pkg::data_t    cache_req_data,
  output logic                     req_start,
  output cache_msg_pkg::req_type_t req_type,
  output cache_geom_pkg::tag_t     req_tag,
  output cache_geom_pkg::index_t   req_index,
  output cache_geom_pkg::data_t    req_data
);

  // Start pulse, one cycle behind the strobe
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_start <= 1'b0;
    end else begin
      req_start <= cache_req_valid;
    end
  end

  // Held request fields, stable until the next strobe
  always_ff @(posedge clk) begin
    if (cache_req_valid) begin
      req_type  <= cache_req_type;
      req_tag   <= cache_req_addr[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];  // Bits 31..5
      req_index <= cache_req_addr[`CACHE_ADDR_W-`CACHE_TAG_W-1 -: `CACHE_INDEX_W];
      req_data  <= cache_req_data;  // Store or init word
    end
  end

endmodule

// ==== logic/cache_msg_pkg.sv ====
//--------------------------------------------------------------------------
// Message kinds: processor request type and memory operation
//--------------------------------------------------------------------------

package cache_msg_pkg;

  // Processor request kinds
  // Same codes as the usual mem message: read 0, write 1, init 2
  typedef enum logic [1:0] {
    REQ_READ  = 2'd0,  // Load one word
    REQ_WRITE = 2'd1,  // Store one word, line goes dirty
    REQ_INIT  = 2'd2   // Install a clean line, no memory traffic
  } req_type_t;

  // Memory side operations
  // A write is acknowledged by its response like a read
  typedef enum logic {
    MEM_READ  = 1'b0,  // Refill
    MEM_WRITE = 1'b1   // Writeback of a dirty victim
  } mem_op_t;

endpackage

// ==== logic/cache_geom_pkg.sv ====
//--------------------------------------------------------------------------
// Storage geometry types: address, word, tag, set index, way select
//--------------------------------------------------------------------------

`include "cache_config.svh"

package cache_geom_pkg;

  // Full byte address on both ports
  typedef logic [`CACHE_ADDR_W-1:0]  addr_t;

  // Payload word, one per line
  typedef logic [`CACHE_DATA_W-1:0]  data_t;

  // Line tag, upper address bits
  typedef logic [`CACHE_TAG_W-1:0]   tag_t;

  // Set index, selects one of the sets
  typedef logic [`CACHE_INDEX_W-1:0] index_t;

  // Two ways, one select bit
  typedef logic                      way_t;

endpackage

// ==== logic/cache_config.svh ====
//--------------------------------------------------------------------------
// Cache geometry macros: address, data, index and tag widths, set count
//--------------------------------------------------------------------------

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// Byte address from the processor
`define CACHE_ADDR_W   32

// One word per line
`define CACHE_DATA_W   32

// 8 sets, index in address bits 4..2
`define CACHE_INDEX_W  3
`define CACHE_NUM_SETS 8

// Tag in address bits 31..5
`define CACHE_TAG_W    27

// Bits 1..0 of the address are ignored
// Offset width follows as ADDR_W - TAG_W - INDEX_W

`endif
